// File: include/cluster_defs.svh
//******************************
// Cluster mesh size and field widths
//******************************
`ifndef CLUSTER_DEFS_SVH
`define CLUSTER_DEFS_SVH

// Mesh geometry
`define CLUSTER_NUM_X      2
`define CLUSTER_NUM_Y      2
`define CLUSTER_NUM_GROUPS 4
`define CLUSTER_NUM_HBM    4

// Packet fields
`define CLUSTER_DATA_W     32
`define CLUSTER_DST_W      3

// DMA fields
`define CLUSTER_DMA_LEN_W  8
`define CLUSTER_DMA_ID_W   4
`define CLUSTER_DMA_CNT_W  8

`endif

// File: logic/noc_pkg.sv
//******************************
// Mesh packet destination and router side types
//******************************
`include "cluster_defs.svh"

package noc_pkg;

  // HBM k sits on row k mod NUM_Y, west for the lower half, east otherwise
  typedef enum logic [`CLUSTER_DST_W-1:0] {
    DST_HBM0   = 3'd0,
    DST_HBM1   = 3'd1,
    DST_HBM2   = 3'd2,
    DST_HBM3   = 3'd3,
    DST_PERIPH = 3'd4
  } noc_dst_e;

  // Router sides, opposite side is index xor 2
  typedef enum logic [1:0] {
    PORT_NORTH = 2'd0,
    PORT_EAST  = 2'd1,
    PORT_SOUTH = 2'd2,
    PORT_WEST  = 2'd3
  } router_port_e;

endpackage

// File: logic/dma_pkg.sv
//******************************
// DMA request and status types
//******************************
`include "cluster_defs.svh"

package dma_pkg;

  typedef struct packed {
    logic [`CLUSTER_DMA_LEN_W-1:0] len;
    logic [`CLUSTER_DMA_ID_W-1:0]  id;
  } dma_req_t;

  typedef struct packed {
    logic                          busy;
    logic [`CLUSTER_DMA_CNT_W-1:0] done_count;
    logic [`CLUSTER_DMA_ID_W-1:0]  last_id;
  } dma_meta_t;

endpackage

// File: logic/noc_link_if.sv
//******************************
// One direction of a mesh link
//******************************
`timescale 1ns/1ps
`include "cluster_defs.svh"

interface noc_link_if
  import noc_pkg::*;
();

  logic                       valid;
  logic                       ready;
  noc_dst_e                   dst;
  logic [`CLUSTER_DATA_W-1:0] data;

  // Sender holds valid, dst and data until the handshake edge
  modport tx (
    output valid,
    output dst,
    output data,
    input  ready
  );

  modport rx (
    input  valid,
    input  dst,
    input  data,
    output ready
  );

endinterface

// File: logic/mesh_router.sv
//******************************
// Four-port mesh router, rows-first routing
// with one round-robin output register per side
//******************************
`timescale 1ns/1ps
`include "cluster_defs.svh"

module mesh_router
  import noc_pkg::*;
#(
  parameter int unsigned POS_X = 0,
  parameter int unsigned POS_Y = 0
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  noc_link_if.rx north_rx,
  noc_link_if.rx east_rx,
  noc_link_if.rx south_rx,
  noc_link_if.rx west_rx,
  noc_link_if.tx north_tx,
  noc_link_if.tx east_tx,
  noc_link_if.tx south_tx,
  noc_link_if.tx west_tx
);

  localparam int unsigned NUM_PORTS = 4;

  logic                       in_valid [NUM_PORTS];
  logic                       in_ready [NUM_PORTS];
  noc_dst_e                   in_dst   [NUM_PORTS];
  logic [`CLUSTER_DATA_W-1:0] in_data  [NUM_PORTS];
  router_port_e               in_route [NUM_PORTS];

  logic                       out_valid_q [NUM_PORTS];
  noc_dst_e                   out_dst_q   [NUM_PORTS];
  logic [`CLUSTER_DATA_W-1:0] out_data_q  [NUM_PORTS];
  logic                       out_ready   [NUM_PORTS];
  logic                       out_free    [NUM_PORTS];

  logic [NUM_PORTS-1:0] req     [NUM_PORTS];
  logic [NUM_PORTS-1:0] take    [NUM_PORTS];
  logic                 gnt_any [NUM_PORTS];
  logic [1:0]           gnt_idx [NUM_PORTS];
  logic [1:0]           rr_q    [NUM_PORTS];

  // Exit side at this router by rows first then columns
  function automatic router_port_e route_of(noc_dst_e dst);
    int unsigned  k;
    int unsigned  tgt_x;
    int unsigned  tgt_y;
    router_port_e side;
    k = dst;
    if (dst == DST_PERIPH) begin
      tgt_x = 0;
      tgt_y = 0;
      side  = PORT_SOUTH;
    end else begin
      tgt_y = k % `CLUSTER_NUM_Y;
      tgt_x = (k < `CLUSTER_NUM_Y) ? 0 : `CLUSTER_NUM_X - 1;
      side  = (k < `CLUSTER_NUM_Y) ? PORT_WEST : PORT_EAST;
    end
    if (tgt_y > POS_Y) return PORT_NORTH;
    if (tgt_y < POS_Y) return PORT_SOUTH;
    if (tgt_x > POS_X) return PORT_EAST;
    if (tgt_x < POS_X) return PORT_WEST;
    return side;
  endfunction

  // Host packets at (0,0) turn back out south to the periph port
  // Horizontal traffic never turns
  function automatic bit turn_ok(int unsigned i, int unsigned o);
    if (i == o) return (o == PORT_SOUTH && POS_X == 0 && POS_Y == 0);
    if (i == PORT_EAST || i == PORT_WEST) begin
      return (o == (i ^ 2));
    end
    return 1'b1;
  endfunction

  assign in_valid[PORT_NORTH] = north_rx.valid;
  assign in_dst[PORT_NORTH]   = north_rx.dst;
  assign in_data[PORT_NORTH]  = north_rx.data;
  assign north_rx.ready       = in_ready[PORT_NORTH];
  assign in_valid[PORT_EAST]  = east_rx.valid;
  assign in_dst[PORT_EAST]    = east_rx.dst;
  assign in_data[PORT_EAST]   = east_rx.data;
  assign east_rx.ready        = in_ready[PORT_EAST];
  assign in_valid[PORT_SOUTH] = south_rx.valid;
  assign in_dst[PORT_SOUTH]   = south_rx.dst;
  assign in_data[PORT_SOUTH]  = south_rx.data;
  assign south_rx.ready       = in_ready[PORT_SOUTH];
  assign in_valid[PORT_WEST]  = west_rx.valid;
  assign in_dst[PORT_WEST]    = west_rx.dst;
  assign in_data[PORT_WEST]   = west_rx.data;
  assign west_rx.ready        = in_ready[PORT_WEST];

  assign north_tx.valid        = out_valid_q[PORT_NORTH];
  assign north_tx.dst          = out_dst_q[PORT_NORTH];
  assign north_tx.data         = out_data_q[PORT_NORTH];
  assign out_ready[PORT_NORTH] = north_tx.ready;
  assign east_tx.valid         = out_valid_q[PORT_EAST];
  assign east_tx.dst           = out_dst_q[PORT_EAST];
  assign east_tx.data          = out_data_q[PORT_EAST];
  assign out_ready[PORT_EAST]  = east_tx.ready;
  assign south_tx.valid        = out_valid_q[PORT_SOUTH];
  assign south_tx.dst          = out_dst_q[PORT_SOUTH];
  assign south_tx.data         = out_data_q[PORT_SOUTH];
  assign out_ready[PORT_SOUTH] = south_tx.ready;
  assign west_tx.valid         = out_valid_q[PORT_WEST];
  assign west_tx.dst           = out_dst_q[PORT_WEST];
  assign west_tx.data          = out_data_q[PORT_WEST];
  assign out_ready[PORT_WEST]  = west_tx.ready;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    assign in_route[p] = route_of(in_dst[p]);
    // Register takes a word when empty or emptying this cycle
    assign out_free[p] = !out_valid_q[p] || out_ready[p];
  end

  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        req[o][i] = in_valid[i] && (in_route[i] == o) && turn_ok(i, o);
      end
    end
  end

  // Round-robin search starts after the last winner
  always_comb begin
    logic [1:0] cand;
    cand = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      gnt_any[o] = 1'b0;
      gnt_idx[o] = rr_q[o];
      for (int k = 1; k <= NUM_PORTS; k++) begin
        cand = rr_q[o] + 2'(k);
        if (!gnt_any[o] && req[o][cand]) begin
          gnt_any[o] = 1'b1;
          gnt_idx[o] = cand;
        end
      end
    end
  end

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_in
    for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_take
      if (turn_ok(i, o)) begin : gen_legal
        assign take[i][o] = gnt_any[o] && (gnt_idx[o] == i) && out_free[o];
      end else begin : gen_never
        assign take[i][o] = 1'b0;
      end
    end
    assign in_ready[i] = !in_valid[i] || (|take[i]);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        out_valid_q[o] <= 1'b0;
        rr_q[o]        <= '0;
      end
    end else begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (gnt_any[o] && out_free[o]) begin
          out_valid_q[o] <= 1'b1;
          rr_q[o]        <= gnt_idx[o];
        end else if (out_ready[o]) begin
          out_valid_q[o] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (gnt_any[o] && out_free[o]) begin
        out_dst_q[o]  <= in_dst[gnt_idx[o]];
        out_data_q[o] <= in_data[gnt_idx[o]];
      end
    end
  end

endmodule

// File: logic/group_dma.sv
//******************************
// Group DMA front end, request skid buffer,
// transfer countdown and status register
//******************************
`timescale 1ns/1ps
`include "cluster_defs.svh"

module group_dma
  import dma_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  dma_req_t  dma_req_i,
  input  logic      dma_req_valid_i,
  output logic      dma_req_ready_o,
  output dma_meta_t dma_meta_o
);

  dma_req_t                      slot_q [2];
  logic                          wr_ptr_q;
  logic                          rd_ptr_q;
  logic [1:0]                    fill_q;
  logic                          push;
  logic                          pop;

  logic                          busy_q;
  logic [`CLUSTER_DMA_LEN_W-1:0] remain_q;
  logic [`CLUSTER_DMA_ID_W-1:0]  cur_id_q;
  logic [`CLUSTER_DMA_CNT_W-1:0] done_cnt_q;
  logic [`CLUSTER_DMA_ID_W-1:0]  last_id_q;
  logic                          finish;
  dma_meta_t                     meta_q;

  assign dma_req_ready_o = (fill_q != 2'd2);
  assign push            = dma_req_valid_i && dma_req_ready_o;
  assign finish          = busy_q && (remain_q == `CLUSTER_DMA_LEN_W'(1));
  // Next transfer loads on the completion edge, so busy has no gap
  assign pop             = (!busy_q || finish) && (fill_q != 2'd0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q[wr_ptr_q] <= dma_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      fill_q   <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      fill_q <= fill_q + 2'(push) - 2'(pop);
    end
  end

  // Zero length still takes one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      remain_q   <= '0;
      cur_id_q   <= '0;
      done_cnt_q <= '0;
      last_id_q  <= '0;
    end else begin
      if (finish) begin
        done_cnt_q <= done_cnt_q + 1'b1;
        last_id_q  <= cur_id_q;
      end
      if (pop) begin
        busy_q   <= 1'b1;
        remain_q <= (slot_q[rd_ptr_q].len == '0) ? `CLUSTER_DMA_LEN_W'(1)
                                                  : slot_q[rd_ptr_q].len;
        cur_id_q <= slot_q[rd_ptr_q].id;
      end else if (finish) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q <= '0;
    end else begin
      meta_q <= '{busy: busy_q, done_count: done_cnt_q, last_id: last_id_q};
    end
  end

  assign dma_meta_o = meta_q;

endmodule

// File: logic/cluster_mesh_top.sv
//******************************
// 2x2 cluster mesh, four routers, four DMA
// front ends and the edge ports
//******************************
`timescale 1ns/1ps
`include "cluster_defs.svh"

module cluster_mesh_top
  import noc_pkg::*;
  import dma_pkg::*;
(
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  // Host injection at the south of group (0,0)
  input  logic                                             host_valid_i,
  input  noc_dst_e                                         host_dst_i,
  input  logic [`CLUSTER_DATA_W-1:0]                       host_data_i,
  output logic                                             host_ready_o,
  // Memory egress
  output logic [`CLUSTER_NUM_HBM-1:0]                      hbm_valid_o,
  output logic [`CLUSTER_NUM_HBM-1:0][`CLUSTER_DATA_W-1:0] hbm_data_o,
  input  logic [`CLUSTER_NUM_HBM-1:0]                      hbm_ready_i,
  // Peripheral egress
  output logic                                             periph_valid_o,
  output logic [`CLUSTER_DATA_W-1:0]                       periph_data_o,
  input  logic                                             periph_ready_i,
  // DMA request and status
  input  dma_req_t [`CLUSTER_NUM_GROUPS-1:0]               dma_req_i,
  input  logic [`CLUSTER_NUM_GROUPS-1:0]                   dma_req_valid_i,
  output logic [`CLUSTER_NUM_GROUPS-1:0]                   dma_req_ready_o,
  output dma_meta_t [`CLUSTER_NUM_GROUPS-1:0]              dma_meta_o
);

  localparam int unsigned NUM_X    = `CLUSTER_NUM_X;
  localparam int unsigned NUM_Y    = `CLUSTER_NUM_Y;
  localparam int unsigned NUM_TX   = `CLUSTER_NUM_GROUPS * 4;
  localparam int unsigned NUM_EDGE = 2 * (NUM_X + NUM_Y);

  function automatic int unsigned tx_idx(int unsigned x, int unsigned y, int unsigned s);
    return (NUM_Y * x + y) * 4 + s;
  endfunction

  // Link feeding side s of router (x, y), neighbour tx or an edge slot
  function automatic int unsigned rx_idx(int unsigned x, int unsigned y, int unsigned s);
    case (s)
      PORT_NORTH: return (y == NUM_Y - 1) ? NUM_TX + x : tx_idx(x, y + 1, PORT_SOUTH);
      PORT_EAST:  return (x == NUM_X - 1) ? NUM_TX + NUM_X + y : tx_idx(x + 1, y, PORT_WEST);
      PORT_SOUTH: return (y == 0) ? NUM_TX + NUM_X + NUM_Y + x : tx_idx(x, y - 1, PORT_NORTH);
      default:    return (x == 0) ? NUM_TX + 2 * NUM_X + NUM_Y + y : tx_idx(x - 1, y, PORT_EAST);
    endcase
  endfunction

  // Router tx links first, then the edge rx links
  noc_link_if link [NUM_TX + NUM_EDGE] ();

  for (genvar x = 0; x < NUM_X; x++) begin : gen_x
    for (genvar y = 0; y < NUM_Y; y++) begin : gen_y
      localparam int unsigned G    = NUM_Y * x + y;
      localparam int unsigned TX   = G * 4;
      localparam int unsigned RX_N = rx_idx(x, y, PORT_NORTH);
      localparam int unsigned RX_E = rx_idx(x, y, PORT_EAST);
      localparam int unsigned RX_S = rx_idx(x, y, PORT_SOUTH);
      localparam int unsigned RX_W = rx_idx(x, y, PORT_WEST);

      mesh_router #(
        .POS_X (x),
        .POS_Y (y)
      ) i_router (
        .clk_i,
        .arst_n_i,
        .north_rx (link[RX_N]           ),
        .east_rx  (link[RX_E]           ),
        .south_rx (link[RX_S]           ),
        .west_rx  (link[RX_W]           ),
        .north_tx (link[TX + PORT_NORTH]),
        .east_tx  (link[TX + PORT_EAST] ),
        .south_tx (link[TX + PORT_SOUTH]),
        .west_tx  (link[TX + PORT_WEST] )
      );

      group_dma i_dma (
        .clk_i,
        .arst_n_i,
        .dma_req_i       (dma_req_i[G]      ),
        .dma_req_valid_i (dma_req_valid_i[G]),
        .dma_req_ready_o (dma_req_ready_o[G]),
        .dma_meta_o      (dma_meta_o[G]     )
      );

      if (y == NUM_Y - 1) begin : gen_north_edge
        assign link[RX_N].valid             = 1'b0;
        assign link[RX_N].dst               = DST_HBM0;
        assign link[RX_N].data              = '0;
        assign link[TX + PORT_NORTH].ready  = 1'b1;
      end

      if (x == NUM_X - 1) begin : gen_east_edge
        assign link[RX_E].valid             = 1'b0;
        assign link[RX_E].dst               = DST_HBM0;
        assign link[RX_E].data              = '0;
        assign hbm_valid_o[NUM_Y + y]       = link[TX + PORT_EAST].valid;
        assign hbm_data_o[NUM_Y + y]        = link[TX + PORT_EAST].data;
        assign link[TX + PORT_EAST].ready   = hbm_ready_i[NUM_Y + y];
      end

      if (x == 0) begin : gen_west_edge
        assign link[RX_W].valid             = 1'b0;
        assign link[RX_W].dst               = DST_HBM0;
        assign link[RX_W].data              = '0;
        assign hbm_valid_o[y]               = link[TX + PORT_WEST].valid;
        assign hbm_data_o[y]                = link[TX + PORT_WEST].data;
        assign link[TX + PORT_WEST].ready   = hbm_ready_i[y];
      end

      if (y == 0 && x == 0) begin : gen_host_periph
        assign link[RX_S].valid             = host_valid_i;
        assign link[RX_S].dst               = host_dst_i;
        assign link[RX_S].data              = host_data_i;
        assign host_ready_o                 = link[RX_S].ready;
        assign periph_valid_o               = link[TX + PORT_SOUTH].valid;
        assign periph_data_o                = link[TX + PORT_SOUTH].data;
        assign link[TX + PORT_SOUTH].ready  = periph_ready_i;
      end else if (y == 0) begin : gen_south_edge
        assign link[RX_S].valid             = 1'b0;
        assign link[RX_S].dst               = DST_HBM0;
        assign link[RX_S].data              = '0;
        assign link[TX + PORT_SOUTH].ready  = 1'b1;
      end
    end
  end

endmodule

// File: verif/tb_cluster_mesh.sv
//******************************
// Testbench for the cluster mesh, random host
// packets and DMA requests with scoreboards
//******************************
`timescale 1ns/1ps
`include "cluster_defs.svh"

module tb_cluster_mesh import noc_pkg::*, dma_pkg::*; ();

  localparam int CLK_PERIOD  = 4;
  localparam int NUM_PORTS   = `CLUSTER_NUM_HBM + 1;
  localparam int NUM_GROUPS  = `CLUSTER_NUM_GROUPS;
  localparam int NUM_PKT     = 160;
  localparam int PKT_BOUND   = 24;
  localparam int BURST_REQ   = 6;
  localparam int NUM_DMA     = 16;
  localparam int DMA_LEN_MAX = 47;
  localparam int WATCHDOG_CYCLES = NUM_PKT * PKT_BOUND
                                 + NUM_GROUPS * NUM_DMA * (DMA_LEN_MAX + 4) + 500;

  logic                                             clk_i;
  logic                                             arst_n_i;
  logic                                             host_valid_i;
  noc_dst_e                                         host_dst_i;
  logic [`CLUSTER_DATA_W-1:0]                       host_data_i;
  logic                                             host_ready_o;
  logic [`CLUSTER_NUM_HBM-1:0]                      hbm_valid_o;
  logic [`CLUSTER_NUM_HBM-1:0][`CLUSTER_DATA_W-1:0] hbm_data_o;
  logic [`CLUSTER_NUM_HBM-1:0]                      hbm_ready_i;
  logic                                             periph_valid_o;
  logic [`CLUSTER_DATA_W-1:0]                       periph_data_o;
  logic                                             periph_ready_i;
  dma_req_t [`CLUSTER_NUM_GROUPS-1:0]               dma_req_i;
  logic [`CLUSTER_NUM_GROUPS-1:0]                   dma_req_valid_i;
  logic [`CLUSTER_NUM_GROUPS-1:0]                   dma_req_ready_o;
  dma_meta_t [`CLUSTER_NUM_GROUPS-1:0]              dma_meta_o;

  // Egress ports 0..3 are HBM and port 4 is the peripheral port
  logic                       eg_valid   [NUM_PORTS];
  logic                       eg_ready   [NUM_PORTS];
  logic [`CLUSTER_DATA_W-1:0] eg_data    [NUM_PORTS];
  logic                       prev_valid [NUM_PORTS];
  logic                       prev_ready [NUM_PORTS];
  logic [`CLUSTER_DATA_W-1:0] prev_data  [NUM_PORTS];
  logic [`CLUSTER_DATA_W-1:0] exp_q      [NUM_PORTS][$];

  logic [`CLUSTER_DMA_ID_W-1:0]  dma_id_q [NUM_GROUPS][$];
  int                            dma_t_q  [NUM_GROUPS][$];
  logic [`CLUSTER_DMA_CNT_W-1:0] prev_cnt [NUM_GROUPS];
  int  accepted   [NUM_GROUPS];
  int  stall_seen [NUM_GROUPS];
  int  dma_sent   [NUM_GROUPS];
  bit  dma_taken  [NUM_GROUPS];

  integer seed = 32'h31619d8b;
  int     cyc;
  int     post_rst;
  int     pkts_sent;
  bit     host_taken;
  int     route_err;
  int     hold_err;
  int     dma_err;
  int     reset_err;

  cluster_mesh_top uut (
    .clk_i           (clk_i          ),
    .arst_n_i        (arst_n_i       ),
    .host_valid_i    (host_valid_i   ),
    .host_dst_i      (host_dst_i     ),
    .host_data_i     (host_data_i    ),
    .host_ready_o    (host_ready_o   ),
    .hbm_valid_o     (hbm_valid_o    ),
    .hbm_data_o      (hbm_data_o     ),
    .hbm_ready_i     (hbm_ready_i    ),
    .periph_valid_o  (periph_valid_o ),
    .periph_data_o   (periph_data_o  ),
    .periph_ready_i  (periph_ready_i ),
    .dma_req_i       (dma_req_i      ),
    .dma_req_valid_i (dma_req_valid_i),
    .dma_req_ready_o (dma_req_ready_o),
    .dma_meta_o      (dma_meta_o     )
  );

  always_comb begin
    for (int k = 0; k < `CLUSTER_NUM_HBM; k++) begin
      eg_valid[k] = hbm_valid_o[k];
      eg_data[k]  = hbm_data_o[k];
      eg_ready[k] = hbm_ready_i[k];
    end
    eg_valid[NUM_PORTS-1] = periph_valid_o;
    eg_data[NUM_PORTS-1]  = periph_data_o;
    eg_ready[NUM_PORTS-1] = periph_ready_i;
  end

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, traffic did not drain", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic int rand_between(int lo, int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % 32'(hi - lo + 1));
  endfunction

  function automatic string sig_name(string field, int p);
    if (p < `CLUSTER_NUM_HBM) return $sformatf("hbm_%s_o[%0d]", field, p);
    return $sformatf("periph_%s_o", field);
  endfunction

  function automatic bit all_drained();
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (exp_q[p].size() != 0) return 1'b0;
    end
    for (int g = 0; g < NUM_GROUPS; g++) begin
      if (dma_id_q[g].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic bit stim_done();
    if (pkts_sent < NUM_PKT || host_valid_i || dma_req_valid_i != '0) return 1'b0;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      if (dma_sent[g] < NUM_DMA) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Valid and payload are held until the handshake edge
  task automatic drive_host();
    if (!host_valid_i || host_taken) begin
      host_taken = 1'b0;
      if (pkts_sent < NUM_PKT && rand_between(0, 3) != 0) begin
        host_valid_i = 1'b1;
        host_dst_i   = noc_dst_e'(3'(rand_between(0, 4)));
        host_data_i  = $random(seed);
        pkts_sent++;
      end else begin
        host_valid_i = 1'b0;
      end
    end
  endtask

  // Long back-to-back requests first to fill the skid buffer
  task automatic drive_dma();
    for (int g = 0; g < NUM_GROUPS; g++) begin
      if (!dma_req_valid_i[g] || dma_taken[g]) begin
        dma_taken[g] = 1'b0;
        dma_req_valid_i[g] = 1'b0;
        if (dma_sent[g] < BURST_REQ) begin
          dma_req_valid_i[g] = 1'b1;
          dma_req_i[g].len   = 8'(rand_between(16, DMA_LEN_MAX));
        end else if (dma_sent[g] < NUM_DMA && rand_between(0, 2) == 0) begin
          dma_req_valid_i[g] = 1'b1;
          dma_req_i[g].len   = 8'(rand_between(0, 7));
        end
        if (dma_req_valid_i[g]) begin
          dma_req_i[g].id = 4'(rand_between(0, 15));
          dma_sent[g]++;
        end
      end
    end
  endtask

  task automatic drive_ready();
    if (pkts_sent >= NUM_PKT / 2) begin
      for (int k = 0; k < `CLUSTER_NUM_HBM; k++) begin
        hbm_ready_i[k] = (rand_between(0, 9) < 6);
      end
      periph_ready_i = (rand_between(0, 9) < 6);
    end
  endtask

  task automatic check_egress(int p);
    if (eg_valid[p] && eg_ready[p]) begin
      assert (exp_q[p].size() > 0) else begin
        route_err++;
        $display("Unexpected packet on %s, data %h", sig_name("data", p), eg_data[p]);
      end
      if (exp_q[p].size() > 0) begin
        assert (eg_data[p] == exp_q[p][0]) else begin
          route_err++;
          $display("FAILED %s exp=%h got=%h", sig_name("data", p), exp_q[p][0], eg_data[p]);
        end
        void'(exp_q[p].pop_front());
      end
    end
    if (prev_valid[p] && !prev_ready[p]) begin
      assert (eg_valid[p]) else begin
        hold_err++;
        $display("FAILED %s exp=%h got=%h", sig_name("valid", p), 1'b1, eg_valid[p]);
      end
      assert (eg_data[p] == prev_data[p]) else begin
        hold_err++;
        $display("FAILED %s exp=%h got=%h", sig_name("data", p), prev_data[p], eg_data[p]);
      end
    end
    prev_valid[p] = eg_valid[p];
    prev_ready[p] = eg_ready[p];
    prev_data[p]  = eg_data[p];
  endtask

  task automatic check_dma(int g);
    logic [`CLUSTER_DMA_CNT_W-1:0] cnt;
    cnt = dma_meta_o[g].done_count;
    if (cnt != prev_cnt[g]) begin
      assert (cnt == prev_cnt[g] + 8'd1) else begin
        dma_err++;
        $display("FAILED dma_meta_o[%0d].done_count exp=%h got=%h", g, prev_cnt[g] + 8'd1, cnt);
      end
      assert (dma_id_q[g].size() > 0) else begin
        dma_err++;
        $display("Group %0d reported a DMA completion with no request outstanding", g);
      end
      if (dma_id_q[g].size() > 0) begin
        assert (dma_meta_o[g].last_id == dma_id_q[g][0]) else begin
          dma_err++;
          $display("FAILED dma_meta_o[%0d].last_id exp=%h got=%h", g, dma_id_q[g][0],
                   dma_meta_o[g].last_id);
        end
        void'(dma_id_q[g].pop_front());
        void'(dma_t_q[g].pop_front());
      end
      prev_cnt[g] = cnt;
    end
    // Accept, load and status register give three cycles of slack
    if (dma_t_q[g].size() > 0 && cyc - dma_t_q[g][0] >= 3) begin
      assert (dma_meta_o[g].busy) else begin
        dma_err++;
        $display("FAILED dma_meta_o[%0d].busy exp=%h got=%h", g, 1'b1, dma_meta_o[g].busy);
      end
    end
    if (dma_req_valid_i[g] && dma_req_ready_o[g]) begin
      dma_id_q[g].push_back(dma_req_i[g].id);
      dma_t_q[g].push_back(cyc);
      dma_taken[g] = 1'b1;
      accepted[g]++;
    end else if (dma_req_valid_i[g]) begin
      stall_seen[g]++;
    end
  endtask

  always @(posedge clk_i) begin
    cyc++;
    if (!arst_n_i) begin
      post_rst = 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        prev_valid[p] = 1'b0;
      end
      for (int g = 0; g < NUM_GROUPS; g++) begin
        prev_cnt[g] = '0;
      end
    end else begin
      post_rst++;
    end
    if (post_rst <= 1) begin
      assert (hbm_valid_o == '0) else begin
        reset_err++;
        $display("FAILED hbm_valid_o exp=%h got=%h", 4'h0, hbm_valid_o);
      end
      assert (!periph_valid_o) else begin
        reset_err++;
        $display("FAILED periph_valid_o exp=%h got=%h", 1'b0, periph_valid_o);
      end
      assert (dma_meta_o == '0) else begin
        reset_err++;
        $display("FAILED dma_meta_o exp=%h got=%h", 52'h0, dma_meta_o);
      end
    end
    if (post_rst == 1) begin
      assert (host_ready_o) else begin
        reset_err++;
        $display("FAILED host_ready_o exp=%h got=%h", 1'b1, host_ready_o);
      end
      assert (dma_req_ready_o == '1) else begin
        reset_err++;
        $display("FAILED dma_req_ready_o exp=%h got=%h", 4'hf, dma_req_ready_o);
      end
    end
    if (post_rst >= 1) begin
      if (host_valid_i && host_ready_o) begin
        exp_q[int'(host_dst_i)].push_back(host_data_i);
        host_taken = 1'b1;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        check_egress(p);
      end
      for (int g = 0; g < NUM_GROUPS; g++) begin
        check_dma(g);
      end
    end
  end

  initial begin
    host_valid_i    = 1'b0;
    host_dst_i      = DST_HBM0;
    host_data_i     = '0;
    hbm_ready_i     = '1;
    periph_ready_i  = 1'b1;
    dma_req_i       = '0;
    dma_req_valid_i = '0;
    arst_n_i        = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    while (!stim_done()) begin
      @(negedge clk_i);
      drive_host();
      drive_dma();
      drive_ready();
    end
    hbm_ready_i    = '1;
    periph_ready_i = 1'b1;
    while (!all_drained()) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    for (int g = 0; g < NUM_GROUPS; g++) begin
      assert (dma_meta_o[g].done_count == 8'(accepted[g])) else begin
        dma_err++;
        $display("FAILED dma_meta_o[%0d].done_count exp=%h got=%h", g, 8'(accepted[g]),
                 dma_meta_o[g].done_count);
      end
      assert (stall_seen[g] > 0) else begin
        dma_err++;
        $display("Group %0d never showed DMA back-pressure", g);
      end
    end
    $display("Errors: routing=%0d hold=%0d dma=%0d reset=%0d total=%0d", route_err, hold_err,
             dma_err, reset_err, route_err + hold_err + dma_err + reset_err);
    if (route_err + hold_err + dma_err + reset_err == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
logic/noc_pkg.sv
logic/dma_pkg.sv
logic/noc_link_if.sv
logic/mesh_router.sv
logic/group_dma.sv
logic/cluster_mesh_top.sv
verif/tb_cluster_mesh.sv

// File: run.sh
#!/bin/sh
# Build and run the cluster mesh testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_cluster_mesh -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
